// ==== design/mm_cfg.svh ====
// Sizes for the 4x4 by 4x4 block matrix multiply, built from 2x2 blocks
// Depths must equal block count times inner block count
// Accumulator width must hold MM_INNER_BLKS * MM_BLK products of two elements
`ifndef MM_CFG_SVH
`define MM_CFG_SVH

// Element and accumulator widths
`define MM_ELEM_W      8
`define MM_ACC_W       20

// Block edge length, in elements
`define MM_BLK         2

// Block counts along each dimension
`define MM_INNER_BLKS  2
`define MM_ROW_BLKS    2
`define MM_COL_BLKS    2
`define MM_OUT_BLKS    4

// Buffer depths in blocks, and their address widths
`define MM_W_DEPTH     4
`define MM_N_DEPTH     4
`define MM_W_ADDR_W    2
`define MM_N_ADDR_W    2

`endif

// ==== design/mm_pkg.sv ====
// Element and block types shared by the buffers, the MAC and the top level
// Blocks are indexed [row][col], both elements and sums are signed
`include "mm_cfg.svh"

package mm_pkg;

    // One signed matrix element
    typedef logic signed [`MM_ELEM_W-1:0] elem_t;

    // One input block, element [i][j] is row i, column j
    // Row 0 sits in the lower half of the packed word
    typedef elem_t [`MM_BLK-1:0][`MM_BLK-1:0] blk_t;

    // One signed accumulated element
    typedef logic signed [`MM_ACC_W-1:0] acc_t;

    // One result block, same [row][col] order as blk_t
    typedef acc_t [`MM_BLK-1:0][`MM_BLK-1:0] cblk_t;

endpackage

// ==== design/block_buffer.sv ====
// Simple dual-port block store, port A writes and port B reads
// Read data is registered, one cycle after enb, and held while enb is low
// A read and a write of the same address in one cycle returns the old block
`timescale 1ns/100ps

module block_buffer #(
    parameter int DEPTH  = 4,
    parameter int ADDR_W = $clog2(DEPTH)
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              ena,
    input  logic              wea,
    input  logic [ADDR_W-1:0] addra,
    input  mm_pkg::blk_t      dina,
    input  logic              enb,
    input  logic [ADDR_W-1:0] addrb,
    output mm_pkg::blk_t      doutb
);
    import mm_pkg::*;

    // Block storage
    blk_t mem [DEPTH];

    // Write port
    always_ff @(posedge clk) begin
        if (ena && wea) begin
            mem[addra] <= dina;
        end
    end

    // Read port with output register
    // Output register clears on reset, like a BRAM output latch
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            doutb <= '0;
        end else if (enb) begin
            doutb <= mem[addrb];
        end
    end

endmodule

// ==== design/buffer_ctrl.sv ====
// Write address generation, ready tracking and compute issue for both buffers
// W arrives row-block-major, N column-block-major, in any interleaving
// Strobes past a full buffer are dropped, done holds until rst_n
// Result blocks are walked r outer, c inner, k innermost
`timescale 1ns/100ps
`include "mm_cfg.svh"

module buffer_ctrl (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    in_valid_w,
    input  logic                    in_valid_n,
    input  logic                    acc_done,
    // West buffer
    output logic                    w_ena,
    output logic                    w_wea,
    output logic [`MM_W_ADDR_W-1:0] w_addra,
    output logic                    w_enb,
    output logic [`MM_W_ADDR_W-1:0] w_addrb,
    // North buffer
    output logic                    n_ena,
    output logic                    n_wea,
    output logic [`MM_N_ADDR_W-1:0] n_addra,
    output logic                    n_enb,
    output logic [`MM_N_ADDR_W-1:0] n_addrb,
    // MAC strobes and status
    output logic                    mac_en,
    output logic                    mac_first,
    output logic                    mac_last,
    output logic                    done
);
    // Counter widths, each wide enough to hold its terminal count
    localparam int WCW = $clog2(`MM_W_DEPTH + 1);
    localparam int NCW = $clog2(`MM_N_DEPTH + 1);
    localparam int RCW = $clog2(`MM_ROW_BLKS + 1);
    localparam int CCW = $clog2(`MM_COL_BLKS + 1);
    localparam int KCW = $clog2(`MM_INNER_BLKS + 1);
    localparam int FCW = $clog2(`MM_OUT_BLKS + 1);

    typedef enum logic [1:0] {
        S_IDLE,
        S_LOAD,
        S_COMPUTE,
        S_DONE
    } state_t;

    state_t state;
    state_t state_nxt;

    // Write side
    logic [WCW-1:0] w_wcnt;
    logic [NCW-1:0] n_wcnt;
    logic           w_full;
    logic           n_full;
    logic           w_row_end;
    logic           n_col_end;

    // Completed W block-rows and N block-columns
    logic [RCW-1:0] w_ready;
    logic [CCW-1:0] n_ready;

    // Read walk
    logic [RCW-1:0] row;
    logic [CCW-1:0] col;
    logic [KCW-1:0] kstep;
    logic           k_last;
    logic           walk_done;
    logic           busy;
    logic           issue;

    // Finished result blocks
    logic [FCW-1:0] fin_cnt;
    logic           last_block;

    // Write port, straight from the host strobe
    assign w_full  = (w_wcnt == WCW'(`MM_W_DEPTH));
    assign n_full  = (n_wcnt == NCW'(`MM_N_DEPTH));
    assign w_ena   = in_valid_w && !w_full;
    assign w_wea   = w_ena;
    assign w_addra = `MM_W_ADDR_W'(w_wcnt);
    assign n_ena   = in_valid_n && !n_full;
    assign n_wea   = n_ena;
    assign n_addra = `MM_N_ADDR_W'(n_wcnt);

    // Last inner block of a W row or N column is being written
    assign w_row_end = w_ena && ((w_wcnt % `MM_INNER_BLKS) == `MM_INNER_BLKS - 1);
    assign n_col_end = n_ena && ((n_wcnt % `MM_INNER_BLKS) == `MM_INNER_BLKS - 1);

    // Issue a k-step only when row r and column c are both stored
    assign busy   = (state == S_LOAD) || (state == S_COMPUTE);
    assign issue  = busy && !walk_done && (w_ready > row) && (n_ready > col);
    assign k_last = (kstep == KCW'(`MM_INNER_BLKS - 1));

    // Read port and MAC strobes
    assign w_enb     = issue;
    assign n_enb     = issue;
    assign w_addrb   = `MM_W_ADDR_W'(row * `MM_INNER_BLKS + kstep);
    assign n_addrb   = `MM_N_ADDR_W'(col * `MM_INNER_BLKS + kstep);
    assign mac_en    = issue;
    assign mac_first = issue && (kstep == '0);
    assign mac_last  = issue && k_last;

    // Final result block of the job
    assign last_block = acc_done && (fin_cnt == FCW'(`MM_OUT_BLKS - 1));
    assign done       = (state == S_DONE);

    // Next state
    always_comb begin
        state_nxt = state;
        case (state)
            S_IDLE: begin
                if (in_valid_w || in_valid_n) begin
                    state_nxt = S_LOAD;
                end
            end
            S_LOAD: begin
                // Writes and issues overlap here
                if (last_block) begin
                    state_nxt = S_DONE;
                end else if (w_full && n_full) begin
                    state_nxt = S_COMPUTE;
                end
            end
            S_COMPUTE: begin
                if (last_block) begin
                    state_nxt = S_DONE;
                end
            end
            S_DONE: begin
                // Left only through reset
                state_nxt = S_DONE;
            end
            default: begin
                state_nxt = S_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state     <= S_IDLE;
            w_wcnt    <= '0;
            n_wcnt    <= '0;
            w_ready   <= '0;
            n_ready   <= '0;
            row       <= '0;
            col       <= '0;
            kstep     <= '0;
            walk_done <= 1'b0;
            fin_cnt   <= '0;
        end else begin
            state <= state_nxt;

            // Write counters stop at the buffer depth
            if (w_ena) begin
                w_wcnt <= w_wcnt + 1'b1;
            end
            if (n_ena) begin
                n_wcnt <= n_wcnt + 1'b1;
            end

            // Ready counts, visible to issue from the next cycle
            if (w_row_end) begin
                w_ready <= w_ready + 1'b1;
            end
            if (n_col_end) begin
                n_ready <= n_ready + 1'b1;
            end

            // Walk k, then c, then r
            if (issue) begin
                if (k_last) begin
                    kstep <= '0;
                    if (col == CCW'(`MM_COL_BLKS - 1)) begin
                        col <= '0;
                        if (row == RCW'(`MM_ROW_BLKS - 1)) begin
                            // Every k-step of the job has been issued
                            walk_done <= 1'b1;
                        end else begin
                            row <= row + 1'b1;
                        end
                    end else begin
                        col <= col + 1'b1;
                    end
                end else begin
                    kstep <= kstep + 1'b1;
                end
            end

            // Count finished blocks from the MAC
            if (acc_done && (fin_cnt != FCW'(`MM_OUT_BLKS))) begin
                fin_cnt <= fin_cnt + 1'b1;
            end
        end
    end

endmodule

// ==== design/block_mac.sv ====
// 2x2 block multiply-accumulate over the inner dimension
// Strobes must match the buffer read issue, data lags them by one cycle
// Accepts one k-step per cycle, result and acc_done two cycles after data
`timescale 1ns/100ps
`include "mm_cfg.svh"

module block_mac (
    input  logic          clk,
    input  logic          rst_n,
    input  mm_pkg::blk_t  w_blk,
    input  mm_pkg::blk_t  n_blk,
    input  logic          mac_en,
    input  logic          mac_first,
    input  logic          mac_last,
    output logic          acc_done,
    output mm_pkg::cblk_t c_blk
);
    import mm_pkg::*;

    // Strobes aligned with buffer read data
    logic  en_d;
    logic  first_d;
    logic  last_d;

    // Product stage
    cblk_t prod_nxt;
    cblk_t prod;
    logic  p_en;
    logic  p_first;
    logic  p_last;

    // Accumulate stage
    cblk_t acc;
    cblk_t sum;

    // Block product, each element is a dot product of length MM_BLK
    // Operands sign-extend to acc_t before the multiply
    always_comb begin
        for (int i = 0; i < `MM_BLK; i++) begin
            for (int j = 0; j < `MM_BLK; j++) begin
                prod_nxt[i][j] = '0;
                for (int m = 0; m < `MM_BLK; m++) begin
                    prod_nxt[i][j] = prod_nxt[i][j] + w_blk[i][m] * n_blk[m][j];
                end
            end
        end
    end

    // First k-step loads, later steps add
    always_comb begin
        for (int i = 0; i < `MM_BLK; i++) begin
            for (int j = 0; j < `MM_BLK; j++) begin
                sum[i][j] = p_first ? prod[i][j] : acc[i][j] + prod[i][j];
            end
        end
    end

    // Strobe pipeline
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            en_d     <= 1'b0;
            first_d  <= 1'b0;
            last_d   <= 1'b0;
            p_en     <= 1'b0;
            p_first  <= 1'b0;
            p_last   <= 1'b0;
            acc_done <= 1'b0;
        end else begin
            en_d     <= mac_en;
            first_d  <= mac_en && mac_first;
            last_d   <= mac_en && mac_last;
            p_en     <= en_d;
            p_first  <= first_d;
            p_last   <= last_d;
            acc_done <= p_en && p_last;
        end
    end

    // Data pipeline
    always_ff @(posedge clk) begin
        if (en_d) begin
            prod <= prod_nxt;
        end
        if (p_en) begin
            acc <= sum;
        end
        // Present the finished block with acc_done
        if (p_en && p_last) begin
            c_blk <= sum;
        end
    end

endmodule

// ==== design/matmul_top.sv ====
// Block matrix multiply, W streamed into the west buffer, N into the north buffer
// out_valid pulses once per result block, row-major, with no back-pressure
// done stays high after the last block until rst_n
`timescale 1ns/100ps
`include "mm_cfg.svh"

module matmul_top (
    input  logic          clk,
    input  logic          rst_n,
    input  logic          in_valid_w,
    input  mm_pkg::blk_t  in_data_w,
    input  logic          in_valid_n,
    input  mm_pkg::blk_t  in_data_n,
    output logic          out_valid,
    output mm_pkg::cblk_t out_data,
    output logic          done
);
    import mm_pkg::*;

    // West buffer ports
    logic                    w_ena;
    logic                    w_wea;
    logic [`MM_W_ADDR_W-1:0] w_addra;
    logic                    w_enb;
    logic [`MM_W_ADDR_W-1:0] w_addrb;
    blk_t                    w_dout;

    // North buffer ports
    logic                    n_ena;
    logic                    n_wea;
    logic [`MM_N_ADDR_W-1:0] n_addra;
    logic                    n_enb;
    logic [`MM_N_ADDR_W-1:0] n_addrb;
    blk_t                    n_dout;

    // MAC strobes
    logic mac_en;
    logic mac_first;
    logic mac_last;

    block_buffer #(
        .DEPTH  (`MM_W_DEPTH),
        .ADDR_W (`MM_W_ADDR_W)
    ) w_buf (
        .clk   (clk),
        .rst_n (rst_n),
        .ena   (w_ena),
        .wea   (w_wea),
        .addra (w_addra),
        .dina  (in_data_w),
        .enb   (w_enb),
        .addrb (w_addrb),
        .doutb (w_dout)
    );

    block_buffer #(
        .DEPTH  (`MM_N_DEPTH),
        .ADDR_W (`MM_N_ADDR_W)
    ) n_buf (
        .clk   (clk),
        .rst_n (rst_n),
        .ena   (n_ena),
        .wea   (n_wea),
        .addra (n_addra),
        .dina  (in_data_n),
        .enb   (n_enb),
        .addrb (n_addrb),
        .doutb (n_dout)
    );

    // acc_done feeds both the completion count and out_valid
    buffer_ctrl ctrl (
        .clk        (clk),
        .rst_n      (rst_n),
        .in_valid_w (in_valid_w),
        .in_valid_n (in_valid_n),
        .acc_done   (out_valid),
        .w_ena      (w_ena),
        .w_wea      (w_wea),
        .w_addra    (w_addra),
        .w_enb      (w_enb),
        .w_addrb    (w_addrb),
        .n_ena      (n_ena),
        .n_wea      (n_wea),
        .n_addra    (n_addra),
        .n_enb      (n_enb),
        .n_addrb    (n_addrb),
        .mac_en     (mac_en),
        .mac_first  (mac_first),
        .mac_last   (mac_last),
        .done       (done)
    );

    block_mac mac (
        .clk       (clk),
        .rst_n     (rst_n),
        .w_blk     (w_dout),
        .n_blk     (n_dout),
        .mac_en    (mac_en),
        .mac_first (mac_first),
        .mac_last  (mac_last),
        .acc_done  (out_valid),
        .c_blk     (out_data)
    );

endmodule

// ==== test/matmul_checker.sv ====
// Compares each out_valid block with the next E line of test/matmul_stimulus.txt
// Per-job counts restart whenever rst_n is sampled low
// Outputs are sampled on the rising edge, before the DUT registers update
// The first block of a job must follow W row 0 and N column 0 by a fixed latency
`timescale 1ns/100ps
`include "mm_cfg.svh"

module matmul_checker (
    input  logic          clk,
    input  logic          rst_n,
    input  logic          in_valid_w,
    input  logic          in_valid_n,
    input  logic          out_valid,
    input  mm_pkg::cblk_t out_data,
    input  logic          done,
    output int            errors,
    output int            pending
);
    import mm_pkg::*;

    localparam int BLK_ELEMS = `MM_BLK * `MM_BLK;

    // First k-step issues in the cycle after the storing edge, out_valid comes
    // 3 cycles after the last k-step and is sampled at the edge that ends it
    localparam int FIRST_LAT = `MM_INNER_BLKS + 3;

    // Expected elements, BLK_ELEMS per block, row 0 first
    int   exp_q[$];
    // Blocks seen since the last reset
    int   job_blks;
    // W and N strobes seen since the last reset
    int   w_seen;
    int   n_seen;
    // Edges since W row 0 and N column 0 were both stored, -1 before that
    int   ready_edges;
    logic done_q;
    logic valid_q;

    task automatic load_expected();
        int    fd;
        int    code;
        int    e00, e01, e10, e11;
        byte   cmd;
        string rest;
        fd = $fopen("test/matmul_stimulus.txt", "r");
        if (fd == 0) begin
            $display("cannot open test/matmul_stimulus.txt for the expected blocks");
            errors++;
            return;
        end
        while ($fscanf(fd, " %c", cmd) == 1) begin
            if (cmd == "E") begin
                code = $fscanf(fd, "%d %d %d %d", e00, e01, e10, e11);
                if (code != 4) begin
                    $display("expected block line has %0d readable elements instead of 4",
                             code);
                    errors++;
                end else begin
                    exp_q.push_back(e00);
                    exp_q.push_back(e01);
                    exp_q.push_back(e10);
                    exp_q.push_back(e11);
                end
            end else begin
                // Everything else belongs to the driver
                code = $fgets(rest, fd);
            end
        end
        $fclose(fd);
    endtask

    task automatic compare_block(input cblk_t blk);
        int exp_v;
        for (int i = 0; i < `MM_BLK; i++) begin
            for (int j = 0; j < `MM_BLK; j++) begin
                exp_v = exp_q.pop_front();
                if (blk[i][j] !== exp_v) begin
                    $display("FAIL %0t out_data[%0d][%0d] expected %0d actual %0d",
                             $time, i, j, exp_v, blk[i][j]);
                    errors++;
                end
            end
        end
    endtask

    initial begin
        errors      = 0;
        job_blks    = 0;
        w_seen      = 0;
        n_seen      = 0;
        ready_edges = -1;
        done_q      = 1'b0;
        valid_q     = 1'b0;
        load_expected();
        pending = exp_q.size() / BLK_ELEMS;
    end

    always @(posedge clk) begin
        if (!rst_n) begin
            job_blks    = 0;
            w_seen      = 0;
            n_seen      = 0;
            ready_edges = -1;
            done_q      = 1'b0;
            valid_q     = 1'b0;
        end else begin
            if (ready_edges >= 0) begin
                ready_edges++;
            end
            if ($isunknown({out_valid, done})) begin
                $display("out_valid or done is unknown at %0t", $time);
                errors++;
            end
            // Block (0,0) starts as soon as its W row and N column are stored
            if (job_blks == 0 && ((out_valid === 1'b1) != (ready_edges == FIRST_LAT))) begin
                $display("first result block not %0d cycles after W row 0 and N column 0, at %0t",
                         FIRST_LAT, $time);
                errors++;
            end
            if (out_valid === 1'b1) begin
                if (exp_q.size() < BLK_ELEMS) begin
                    $display("out_valid with no expected block left at %0t", $time);
                    errors++;
                end else begin
                    compare_block(out_data);
                end
                job_blks++;
            end
            // Rising done ends the job
            if (done === 1'b1 && !done_q) begin
                if (job_blks != `MM_OUT_BLKS) begin
                    $display("done before all expected blocks, %0d of %0d at %0t",
                             job_blks, `MM_OUT_BLKS, $time);
                    errors++;
                end
                if (!valid_q) begin
                    $display("done at %0t did not follow the final out_valid by one cycle",
                             $time);
                    errors++;
                end
            end
            // Strobes seen at this edge are written at this edge
            if (in_valid_w === 1'b1) begin
                w_seen++;
            end
            if (in_valid_n === 1'b1) begin
                n_seen++;
            end
            if (ready_edges < 0 && w_seen >= `MM_INNER_BLKS && n_seen >= `MM_INNER_BLKS) begin
                ready_edges = 0;
            end
            done_q  = (done === 1'b1);
            valid_q = (out_valid === 1'b1);
        end
        pending = exp_q.size() / BLK_ELEMS;
    end

endmodule

// ==== test/tb_matmul.sv ====
// Reads test/matmul_stimulus.txt, so the simulation must run from the project root
// Inputs change 2 ns after a rising edge, each D command waits at most 200 cycles
// Result values and timing of done are judged by matmul_checker
`timescale 1ns/100ps
`include "mm_cfg.svh"

module tb_matmul;
    import mm_pkg::*;

    localparam int DONE_TIMEOUT = 200;

    logic  clk;
    logic  rst_n;
    logic  in_valid_w;
    blk_t  in_data_w;
    logic  in_valid_n;
    blk_t  in_data_n;
    logic  out_valid;
    cblk_t out_data;
    logic  done;

    // Error counts, driver side and checker side
    int    drv_errors;
    int    chk_errors;
    int    exp_left;

    // 20 ns clock
    always #10 clk = ~clk;

    matmul_top UUT (
        .clk        (clk),
        .rst_n      (rst_n),
        .in_valid_w (in_valid_w),
        .in_data_w  (in_data_w),
        .in_valid_n (in_valid_n),
        .in_data_n  (in_data_n),
        .out_valid  (out_valid),
        .out_data   (out_data),
        .done       (done)
    );

    matmul_checker chk (
        .clk        (clk),
        .rst_n      (rst_n),
        .in_valid_w (in_valid_w),
        .in_valid_n (in_valid_n),
        .out_valid  (out_valid),
        .out_data   (out_data),
        .done       (done),
        .errors     (chk_errors),
        .pending    (exp_left)
    );

    // Reset held for two rising edges, strobes low meanwhile
    task automatic apply_reset();
        rst_n      = 1'b0;
        in_valid_w = 1'b0;
        in_valid_n = 1'b0;
        repeat (2) begin
            @(posedge clk);
            #2;
        end
        rst_n = 1'b1;
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(posedge clk);
            #2;
        end
    endtask

    // Four elements, row 0 first, into one packed block
    task automatic read_block(input int fd, output blk_t blk);
        int code;
        int e00, e01, e10, e11;
        code = $fscanf(fd, "%d %d %d %d", e00, e01, e10, e11);
        if (code != 4) begin
            $display("stimulus block line has %0d readable elements instead of 4", code);
            drv_errors++;
        end
        blk[0][0] = e00[`MM_ELEM_W-1:0];
        blk[0][1] = e01[`MM_ELEM_W-1:0];
        blk[1][0] = e10[`MM_ELEM_W-1:0];
        blk[1][1] = e11[`MM_ELEM_W-1:0];
    endtask

    // One block per strobe, high for exactly one edge
    task automatic strobe_w(input blk_t blk);
        in_data_w  = blk;
        in_valid_w = 1'b1;
        @(posedge clk);
        #2;
        in_valid_w = 1'b0;
    endtask

    task automatic strobe_n(input blk_t blk);
        in_data_n  = blk;
        in_valid_n = 1'b1;
        @(posedge clk);
        #2;
        in_valid_n = 1'b0;
    endtask

    task automatic wait_done();
        int cycles;
        cycles = 0;
        while (done !== 1'b1 && cycles < DONE_TIMEOUT) begin
            @(posedge clk);
            #2;
            cycles++;
        end
        if (done !== 1'b1) begin
            $display("done did not rise within %0d cycles", DONE_TIMEOUT);
            drv_errors++;
        end else begin
            // One more edge so the checker samples done high before any reset
            @(posedge clk);
            #2;
        end
    endtask

    initial begin
        int    fd;
        int    code;
        int    n;
        byte   cmd;
        string rest;
        blk_t  blk;
        logic  stop;
        clk        = 1'b0;
        rst_n      = 1'b0;
        in_valid_w = 1'b0;
        in_data_w  = '0;
        in_valid_n = 1'b0;
        in_data_n  = '0;
        drv_errors = 0;
        stop       = 1'b0;
        apply_reset();

        fd = $fopen("test/matmul_stimulus.txt", "r");
        if (fd == 0) begin
            $display("cannot open test/matmul_stimulus.txt");
            drv_errors++;
            stop = 1'b1;
        end
        while (!stop && $fscanf(fd, " %c", cmd) == 1) begin
            case (cmd)
                "W": begin
                    read_block(fd, blk);
                    strobe_w(blk);
                end
                "N": begin
                    read_block(fd, blk);
                    strobe_n(blk);
                end
                "I": begin
                    code = $fscanf(fd, "%d", n);
                    idle_cycles(n);
                end
                "R": apply_reset();
                "D": begin
                    wait_done();
                    // No point driving further jobs after a lost done
                    stop = (done !== 1'b1);
                end
                // Comments, and E lines that only the checker uses
                "#", "E": code = $fgets(rest, fd);
                default: begin
                    $display("unknown stimulus command '%c'", cmd);
                    drv_errors++;
                    stop = 1'b1;
                end
            endcase
        end
        if (fd != 0) begin
            $fclose(fd);
        end

        // Let the checker see the last edges
        repeat (2) @(posedge clk);
        if (exp_left != 0) begin
            $display("%0d expected result blocks were never produced", exp_left);
            drv_errors++;
        end
        $display("errors: checker %0d, driver %0d", chk_errors, drv_errors);
        if (chk_errors == 0 && drv_errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

// ==== test/matmul_stimulus.txt ====
# W, N: one 2x2 block as e00 e01 e10 e11, signed decimal; E: expected result block, same order
# I n: n idle cycles; R: reset; D: wait for done
I 5
W 1 2 5 6
W 3 4 7 8
W -1 0 4 -2
W 2 -3 1 0
N 1 0 0 1
N -2 1 1 1
N 2 -1 3 2
N 0 1 -1 0
E -1 9 -1 21
E 4 6 20 14
E -8 -1 2 -1
E 1 3 2 -7
D
R
I 2
N 1 2 -1 0
N 2 1 0 -2
N 0 -1 1 1
N -1 0 3 1
W 2 -1 1 1
W 0 3 -2 0
I 6
W 0 4 -3 2
I 3
W 1 -1 2 1
E 3 -2 -4 0
E 8 0 3 0
E -2 3 -1 -6
E 0 3 3 6
D
R
W -128 -128 127 127
N -128 127 -128 127
W -128 -128 127 127
N -128 -128 -128 -128
W -128 127 1 2
N 1 0 0 1
W -128 127 3 4
N 1 0 0 1
W 99 99 99 99
N -77 -77 -77 -77
E 65536 256 -65024 -254
E -256 -256 254 254
E 256 1 -1280 -515
E -256 254 4 6
D

// ==== filelist.f ====
+incdir+design
design/mm_pkg.sv
design/block_buffer.sv
design/buffer_ctrl.sv
design/block_mac.sv
design/matmul_top.sv
test/matmul_checker.sv
test/tb_matmul.sv

// ==== Bender.yml ====
package:
  name: matmul

sources:
  - include_dirs:
      - design
    files:
      - design/mm_pkg.sv
      - design/block_buffer.sv
      - design/buffer_ctrl.sv
      - design/block_mac.sv
      - design/matmul_top.sv
  - target: test
    include_dirs:
      - design
    files:
      - test/matmul_checker.sv
      - test/tb_matmul.sv
